// ==== source/icache_cfg_pkg.sv ====
// ==============================
// icache_cfg_pkg
// cache geometry and AXI bus constants
// ==============================
package icache_cfg_pkg;

    localparam int ADDR_W         = 32;   // byte address
    localparam int DATA_W         = 32;   // instruction word
    localparam int WAYS           = 2;
    localparam int SETS           = 256;
    localparam int INDEX_W        = 8;    // log2 of SETS
    localparam int WORDS_PER_LINE = 4;    // 16-byte line
    localparam int WORD_SEL_W     = 2;
    localparam int BYTE_OFF_W     = 2;    // byte within a word

    // tag takes what index, word select and byte bits leave over
    localparam int TAG_W = ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;

    localparam int DATA_DEPTH = SETS * WORDS_PER_LINE;  // words per way

    // AXI4-Lite read side
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [2:0] AXI_PROT_INSN = 3'b100;  // unprivileged, secure, instruction

endpackage

// ==== source/icache_if_pkg.sv ====
// ==============================
// icache_if_pkg
// fetch, tag entry and AXI read types
// ==============================
package icache_if_pkg;

    import icache_cfg_pkg::*;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;     // set select
        logic [WORD_SEL_W-1:0] word_sel;  // word within line
        logic [BYTE_OFF_W-1:0] byte_off;  // zero for fetches
    } fetch_addr_t;

    typedef struct packed {
        fetch_addr_t addr;  // word aligned
    } fetch_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              err;  // refill failed
    } fetch_resp_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

endpackage

// ==== source/sp_ram.sv ====
// ==============================
// sp_ram
// single-port sync RAM, read-first
// ==============================
`timescale 1ns/10ps

module sp_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 256
) (
    input  logic                     clk,
    input  logic                     en,     // port enable
    input  logic                     we,     // write when enabled
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata   // valid one cycle after en
);

    payload_t mem [DEPTH];  // storage array

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];  // old contents on a write
        end
    end

endmodule

// ==== source/itag_ram.sv ====
// ==============================
// itag_ram
// tag and LRU store, hit and victim logic
// ==============================
`timescale 1ns/10ps

module itag_ram (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                rd_en,
    input  logic [icache_cfg_pkg::INDEX_W-1:0]  index,
    input  logic [icache_cfg_pkg::TAG_W-1:0]    lookup_tag,
    input  logic [icache_cfg_pkg::WAYS-1:0]     tag_we,      // one-hot per way, all on init
    input  icache_if_pkg::tag_entry_t           wr_entry,
    input  logic                                touch_en,    // mark hit way as recent
    output logic                                hit,
    output logic                                hit_way,
    output logic                                victim_way,
    output logic                                fill_done
);

    import icache_cfg_pkg::*;
    import icache_if_pkg::*;

    tag_entry_t       tag_rd [WAYS];  // entries of both ways
    logic [WAYS-1:0]  way_hit;
    logic [TAG_W-1:0] lookup_tag_q;   // tag of the pending lookup
    logic             lru_rd;         // least recently used way
    logic             lru_we;
    logic             lru_wd;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        sp_ram #(.payload_t(tag_entry_t), .DEPTH(SETS)) u_tag (
            .clk   (clk),
            .en    (rd_en | tag_we[w]),
            .we    (tag_we[w]),
            .addr  (index),
            .wdata (wr_entry),
            .rdata (tag_rd[w])
        );
        assign way_hit[w] = tag_rd[w].valid && (tag_rd[w].tag == lookup_tag_q);
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            lookup_tag_q <= lookup_tag;  // lines up with the tag read
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // invalid way first, else the LRU one
    assign victim_way = !tag_rd[0].valid ? 1'b0 :
                        !tag_rd[1].valid ? 1'b1 : lru_rd;

    // fill or touch makes the other way LRU
    assign lru_we = touch_en | (|tag_we);
    assign lru_wd = (|tag_we) ? tag_we[0] : ~hit_way;

    sp_ram #(.payload_t(logic), .DEPTH(SETS)) u_lru (
        .clk   (clk),
        .en    (rd_en | lru_we),
        .we    (lru_we),
        .addr  (index),
        .wdata (lru_wd),
        .rdata (lru_rd)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_done <= 1'b0;
        end else begin
            fill_done <= (|tag_we) & wr_entry.valid;  // invalidations stay quiet
        end
    end

endmodule

// ==== source/idata_ram.sv ====
// ==============================
// idata_ram
// line data of both ways, hit word select
// ==============================
`timescale 1ns/10ps

module idata_ram (
    input  logic                                  clk,
    input  logic                                  rd_en,
    input  logic [icache_cfg_pkg::INDEX_W-1:0]    index,
    input  logic [icache_cfg_pkg::WORD_SEL_W-1:0] word_sel,
    input  logic                                  we,
    input  logic                                  wr_way,
    input  logic [icache_cfg_pkg::DATA_W-1:0]     wdata,
    input  logic                                  hit_way,   // from the tag compare
    output logic [icache_cfg_pkg::DATA_W-1:0]     rd_word
);

    import icache_cfg_pkg::*;

    logic [INDEX_W+WORD_SEL_W-1:0] word_addr;        // set and word
    logic [DATA_W-1:0]             rd_data [WAYS];

    assign word_addr = {index, word_sel};

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic way_we;  // write hits only this way

        assign way_we = we && (wr_way == 1'(w));

        sp_ram #(.payload_t(logic [DATA_W-1:0]), .DEPTH(DATA_DEPTH)) u_data (
            .clk   (clk),
            .en    (rd_en | way_we),
            .we    (way_we),
            .addr  (word_addr),
            .wdata (wdata),
            .rdata (rd_data[w])
        );
    end

    assign rd_word = rd_data[hit_way];

endmodule

// ==== source/icache_ctrl.sv ====
// ==============================
// icache_ctrl
// lookup, AXI4-Lite refill, init walk FSM
// ==============================
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  flush,
    input  logic                                  req_valid,
    output logic                                  req_ready,
    input  icache_if_pkg::fetch_req_t             req,
    output logic                                  resp_valid,
    output icache_if_pkg::fetch_resp_t            resp,
    output logic                                  ar_valid,
    input  logic                                  ar_ready,
    output icache_if_pkg::axi_ar_t                ar,
    input  logic                                  r_valid,
    output logic                                  r_ready,
    input  icache_if_pkg::axi_r_t                 r,
    output logic                                  tag_rd_en,
    output logic [icache_cfg_pkg::INDEX_W-1:0]    index,
    output logic [icache_cfg_pkg::WORD_SEL_W-1:0] word_sel,
    output logic [icache_cfg_pkg::TAG_W-1:0]      lookup_tag,
    output logic [icache_cfg_pkg::WAYS-1:0]       tag_we,
    output icache_if_pkg::tag_entry_t             wr_entry,
    output logic                                  touch_en,
    output logic                                  data_we,
    output logic                                  data_way,
    output logic [icache_cfg_pkg::DATA_W-1:0]     data_wdata,
    input  logic                                  hit,
    input  logic                                  hit_way,
    input  logic                                  victim_way,
    input  logic                                  fill_done,
    input  logic [icache_cfg_pkg::DATA_W-1:0]     rd_word
);

    import icache_cfg_pkg::*;
    import icache_if_pkg::*;

    typedef enum logic [2:0] {
        ST_INIT, ST_IDLE, ST_LOOKUP, ST_ADDR,
        ST_BEAT, ST_TAG_WR, ST_WAIT_FILL, ST_ERR_RESP
    } state_t;

    state_t                state;
    fetch_req_t            req_q;     // request in flight
    logic [INDEX_W-1:0]    init_cnt;  // set being cleared
    logic [WORD_SEL_W-1:0] word_cnt;  // refill word
    logic                  victim_q;  // way being refilled
    logic                  err_q;     // some beat came back bad
    logic                  accept;
    logic                  beat_err;
    logic                  last_beat;

    assign accept    = req_valid && req_ready;
    assign beat_err  = r.resp != AXI_RESP_OKAY;
    assign last_beat = word_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1);

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_INIT;
            init_cnt <= '0;
            word_cnt <= '0;
            victim_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == INDEX_W'(SETS - 1)) state <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (flush) begin
                        init_cnt <= '0;
                        state    <= ST_INIT;  // walk again
                    end else if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        state <= ST_IDLE;
                    end else begin
                        victim_q <= victim_way;  // decided on this read
                        word_cnt <= '0;
                        err_q    <= 1'b0;
                        state    <= ST_ADDR;
                    end
                end
                ST_ADDR: if (ar_ready) state <= ST_BEAT;
                ST_BEAT: begin
                    if (r_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                        err_q    <= err_q | beat_err;
                        if (!last_beat) state <= ST_ADDR;
                        else if (err_q || beat_err) state <= ST_ERR_RESP;
                        else state <= ST_TAG_WR;
                    end
                end
                ST_TAG_WR:    state <= ST_WAIT_FILL;
                ST_WAIT_FILL: if (fill_done) state <= ST_LOOKUP;  // replay
                ST_ERR_RESP:  state <= ST_IDLE;
                default:      state <= ST_INIT;
            endcase
        end
    end

    always_comb begin
        req_ready  = (state == ST_IDLE) && !flush;
        resp_valid = ((state == ST_LOOKUP) && hit) || (state == ST_ERR_RESP);
        resp.err   = state == ST_ERR_RESP;
        resp.data  = resp.err ? '0 : rd_word;

        ar_valid = state == ST_ADDR;
        ar.addr  = {req_q.addr.tag, req_q.addr.index, word_cnt, BYTE_OFF_W'(0)};
        ar.prot  = AXI_PROT_INSN;
        r_ready  = state == ST_BEAT;

        tag_rd_en  = accept || ((state == ST_WAIT_FILL) && fill_done);
        lookup_tag = (state == ST_IDLE) ? req.addr.tag : req_q.addr.tag;
        touch_en   = (state == ST_LOOKUP) && hit;

        case (state)
            ST_INIT: index = init_cnt;
            ST_IDLE: index = req.addr.index;  // read starts on accept
            default: index = req_q.addr.index;
        endcase

        case (state)
            ST_IDLE: word_sel = req.addr.word_sel;
            ST_BEAT: word_sel = word_cnt;       // refill write slot
            default: word_sel = req_q.addr.word_sel;
        endcase

        // ERR_RESP drops the victim since its data is partly overwritten
        case (state)
            ST_INIT:                tag_we = '1;
            ST_TAG_WR, ST_ERR_RESP: tag_we = WAYS'(1) << victim_q;
            default:                tag_we = '0;
        endcase
        wr_entry.valid = state == ST_TAG_WR;
        wr_entry.tag   = req_q.addr.tag;

        data_we    = (state == ST_BEAT) && r_valid;
        data_way   = victim_q;
        data_wdata = r.data;
    end

endmodule

// ==== source/icache_top.sv ====
// ==============================
// icache_top
// two-way icache with AXI4-Lite refill
// ==============================
`timescale 1ns/10ps

module icache_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,      // one-cycle pulse, taken when idle
    input  logic                       req_valid,
    output logic                       req_ready,
    input  icache_if_pkg::fetch_req_t  req,
    output logic                       resp_valid,
    output icache_if_pkg::fetch_resp_t resp,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    output icache_if_pkg::axi_ar_t     ar,
    input  logic                       r_valid,
    output logic                       r_ready,
    input  icache_if_pkg::axi_r_t      r
);

    import icache_cfg_pkg::*;
    import icache_if_pkg::*;

    logic                  tag_rd_en;   // shared by both stores
    logic [INDEX_W-1:0]    index;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [TAG_W-1:0]      lookup_tag;
    logic [WAYS-1:0]       tag_we;
    tag_entry_t            wr_entry;
    logic                  touch_en;
    logic                  data_we;
    logic                  data_way;
    logic [DATA_W-1:0]     data_wdata;
    logic                  hit;
    logic                  hit_way;
    logic                  victim_way;
    logic                  fill_done;
    logic [DATA_W-1:0]     rd_word;

    icache_ctrl u_ctrl (.*);

    itag_ram u_tag (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_en      (tag_rd_en),
        .index      (index),
        .lookup_tag (lookup_tag),
        .tag_we     (tag_we),
        .wr_entry   (wr_entry),
        .touch_en   (touch_en),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .fill_done  (fill_done)
    );

    idata_ram u_data (
        .clk      (clk),
        .rd_en    (tag_rd_en),
        .index    (index),
        .word_sel (word_sel),
        .we       (data_we),
        .wr_way   (data_way),
        .wdata    (data_wdata),
        .hit_way  (hit_way),
        .rd_word  (rd_word)
    );

endmodule

// ==== sim/clk_rst_gen.sv ====
// ==============================
// clk_rst_gen
// testbench clock and power-on reset
// ==============================
`timescale 1ns/10ps

module clk_rst_gen #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;  // release away from the active edge
    end

endmodule

// ==== sim/axi_rom_model.sv ====
// ==============================
// axi_rom_model
// AXI4-Lite read slave, address-derived data
// ==============================
`timescale 1ns/10ps

module axi_rom_model #(
    parameter logic [31:0] PATTERN = 32'h0
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  icache_if_pkg::axi_ar_t ar,
    output logic                   r_valid,
    input  logic                   r_ready,
    output icache_if_pkg::axi_r_t  r,
    input  logic [1:0]             ar_delay,  // wait before ar_ready
    input  logic [1:0]             r_delay,   // wait before r_valid
    input  logic [31:0]            err_lo,    // SLVERR window, inclusive
    input  logic [31:0]            err_hi     // exclusive
);

    import icache_cfg_pkg::*;

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {M_IDLE, M_AR_WAIT, M_AR, M_R_WAIT, M_R} mstate_t;

    mstate_t     state;
    logic [1:0]  cnt;     // delay countdown
    logic [31:0] addr_q;  // captured read address

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= M_IDLE;
            cnt      <= '0;
            addr_q   <= '0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r        <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (ar_valid) begin
                        cnt   <= ar_delay;
                        state <= M_AR_WAIT;
                    end
                end
                M_AR_WAIT: begin
                    if (cnt == 2'd0) begin
                        ar_ready <= 1'b1;
                        state    <= M_AR;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                M_AR: begin
                    if (ar_valid) begin  // handshake on this edge
                        ar_ready <= 1'b0;
                        addr_q   <= ar.addr;
                        cnt      <= r_delay;
                        state    <= M_R_WAIT;
                    end
                end
                M_R_WAIT: begin
                    if (cnt == 2'd0) begin
                        r_valid <= 1'b1;
                        r.data  <= (addr_q >> 2) ^ PATTERN;  // word address based
                        r.resp  <= (addr_q >= err_lo && addr_q < err_hi) ?
                                   RESP_SLVERR : AXI_RESP_OKAY;
                        state   <= M_R;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                M_R: begin
                    if (r_ready) begin
                        r_valid <= 1'b0;
                        state   <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

// ==== sim/tb_icache.sv ====
// ==============================
// tb_icache
// directed tests of the two-way icache
// ==============================
`timescale 1ns/10ps

module tb_icache;

    import icache_cfg_pkg::*;
    import icache_if_pkg::*;

    localparam logic [31:0] ROM_PATTERN = 32'hc3a5_5a3c;  // model data is word addr ^ this
    localparam logic [31:0] LINE_X      = 32'h0000_1000;  // set 0x00
    localparam logic [31:0] LINE_A      = 32'h0001_0400;  // A, B and C share set 0x40
    localparam logic [31:0] LINE_B      = 32'h0002_0400;
    localparam logic [31:0] LINE_C      = 32'h0003_0400;
    localparam logic [31:0] ERR_LO      = 32'h0080_0800;  // SLVERR on word 0 of ERR_LINE only
    localparam logic [31:0] ERR_HI      = 32'h0080_0804;
    localparam logic [31:0] ERR_LINE    = 32'h0080_0800;
    localparam int RAND_FETCHES = 200;
    localparam int FETCHES      = 16 + RAND_FETCHES;
    localparam int MISS_CYCLES  = 64;  // refill at max delays, rounded up
    localparam int CYCLE_LIMIT  = 2 * (FETCHES * MISS_CYCLES + 3 * SETS);

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic        req_valid;
    logic        req_ready;
    fetch_req_t  req;
    logic        resp_valid;
    fetch_resp_t resp;
    logic        ar_valid;
    logic        ar_ready;
    axi_ar_t     ar;
    logic        r_valid;
    logic        r_ready;
    axi_r_t      r;
    logic [1:0]  ar_delay;
    logic [1:0]  r_delay;
    logic [31:0] err_lo;
    logic [31:0] err_hi;
    logic        rand_delays;               // random AXI stalls on
    logic [31:0] lfsr_state = 32'd71118;
    logic [31:0] ar_log [$];                // addresses of AR handshakes
    int          ar_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;

    clk_rst_gen #(.PERIOD_NS(4.0), .RST_CYCLES(4)) u_clk (.clk(clk), .arst_n(arst_n));
    icache_top DUT (.*);
    axi_rom_model #(.PATTERN(ROM_PATTERN)) u_rom (.*);

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};  // one step per bit
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return (addr >> 2) ^ ROM_PATTERN;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    // new stall counts each cycle, off the active edge
    always @(negedge clk) begin : delay_pick
        logic [31:0] v;
        if (rand_delays) begin
            rand_bits(2, v);
            ar_delay <= v[1:0];
            rand_bits(2, v);
            r_delay <= v[1:0];
        end
    end

    always @(negedge clk) begin
        if (ar_valid && ar_ready) begin  // completes on the next rising edge
            ar_count++;
            ar_log.push_back(ar.addr);
            check("ar.prot[2]", ar.prot[2], 1'b1);  // instruction access
        end
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: no end of test after %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    // starts at a negedge in the walk, counts cycles until ready
    task automatic walk_wait(output int n);
        n = 0;
        while (!req_ready) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic fetch(input logic [31:0] addr, output logic [31:0] data,
                         output logic err, output int lat);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= fetch_req_t'(addr);
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);                   // accepted on this edge
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        data = resp.data;
        err  = resp.err;
        @(negedge clk);
        check("resp_valid", resp_valid, 1'b0);  // single-cycle response
    endtask

    task automatic fetch_check(input logic [31:0] addr, input int exp_ars, input logic exp_err);
        logic [31:0] data;
        logic        err;
        int          lat;
        int          ars_before;
        ars_before = ar_count;
        fetch(addr, data, err, lat);
        check("resp.err", err, exp_err);
        if (!exp_err) check("resp.data", data, expected_word(addr));
        check("ar handshakes", ar_count - ars_before, exp_ars);
        if (exp_ars == 0) check("hit latency", lat, 1);
    endtask

    task automatic flush_cache();
        int walk;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check("req_ready", req_ready, 1'b0);
        walk_wait(walk);
        check("flush walk cycles", walk, SETS);
    endtask

    task automatic reset_and_first_fetch();
        int start_err;
        int walk;
        start_err = errors;
        check("req_ready", req_ready, 1'b0);
        check("resp_valid", resp_valid, 1'b0);
        check("ar_valid", ar_valid, 1'b0);
        check("r_ready", r_ready, 1'b0);
        walk_wait(walk);
        check("init walk cycles", walk, SETS);
        ar_log.delete();
        fetch_check(LINE_X + 32'd4, 4, 1'b0);
        check("ar log size", ar_log.size(), 4);
        foreach (ar_log[i]) check("ar.addr", ar_log[i], LINE_X + 32'(4 * i));  // words 0 to 3
        end_test("reset and first fetch", start_err);
    endtask

    task automatic same_line_hits();
        int start_err;
        start_err = errors;
        fetch_check(LINE_X, 0, 1'b0);
        fetch_check(LINE_X + 32'd8, 0, 1'b0);
        fetch_check(LINE_X + 32'd12, 0, 1'b0);
        end_test("same line hits", start_err);
    endtask

    task automatic lru_replacement();
        int start_err;
        start_err = errors;
        fetch_check(LINE_A, 4, 1'b0);
        fetch_check(LINE_B + 32'd4, 4, 1'b0);
        fetch_check(LINE_A + 32'd8, 0, 1'b0);  // B is now LRU
        fetch_check(LINE_C, 4, 1'b0);          // evicts B
        fetch_check(LINE_A + 32'd12, 0, 1'b0);
        fetch_check(LINE_B, 4, 1'b0);
        end_test("lru replacement", start_err);
    endtask

    task automatic error_refill();
        int start_err;
        start_err = errors;
        fetch_check(ERR_LINE + 32'd8, 4, 1'b1);  // bad first beat, good last beat
        fetch_check(ERR_LINE + 32'd8, 4, 1'b1);  // line was not installed
        end_test("error refill", start_err);
    endtask

    task automatic flush_walk();
        int start_err;
        start_err = errors;
        fetch_check(LINE_A, 0, 1'b0);
        flush_cache();
        fetch_check(LINE_A, 4, 1'b0);
        end_test("flush walk", start_err);
    endtask

    task automatic random_fetches();
        logic [31:0] addrs [$];
        logic [31:0] v;
        logic [31:0] a;
        logic        ref_valid [4][2];  // reference two-way LRU over sets 0x10 to 0x13
        logic [19:0] ref_tag [4][2];
        logic        ref_lru [4];
        logic        w;
        logic        miss;
        int          s;
        int          ref_misses;
        int          ars_before;
        int          start_err;
        start_err  = errors;
        ref_misses = 0;
        for (int i = 0; i < 4; i++) begin
            ref_valid[i][0] = 1'b0;
            ref_valid[i][1] = 1'b0;
            ref_lru[i]      = 1'b0;
        end
        for (int i = 0; i < RAND_FETCHES; i++) begin
            rand_bits(6, v);  // tag, set, word
            addrs.push_back(32'h0020_0000 + (v[5:4] << 12) + ((32'h10 + v[3:2]) << 4)
                            + (v[1:0] << 2));
        end
        @(posedge clk);
        rand_delays = 1'b1;
        ars_before  = ar_count;
        foreach (addrs[i]) begin
            a = addrs[i];
            s = a[5:4];
            if (ref_valid[s][0] && ref_tag[s][0] == a[31:12]) begin
                w    = 1'b0;
                miss = 1'b0;
            end else if (ref_valid[s][1] && ref_tag[s][1] == a[31:12]) begin
                w    = 1'b1;
                miss = 1'b0;
            end else begin
                miss = 1'b1;
                w    = !ref_valid[s][0] ? 1'b0 : !ref_valid[s][1] ? 1'b1 : ref_lru[s];
                ref_valid[s][w] = 1'b1;
                ref_tag[s][w]   = a[31:12];
                ref_misses++;
            end
            ref_lru[s] = ~w;  // other way is now LRU
            fetch_check(a, miss ? 4 : 0, 1'b0);
        end
        check("miss count", (ar_count - ars_before) / 4, ref_misses);
        end_test("random fetches", start_err);
    endtask

    initial begin
        flush       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        err_lo      = ERR_LO;
        err_hi      = ERR_HI;
        ar_delay    = 2'd0;
        r_delay     = 2'd0;
        rand_delays = 1'b0;
        wait (arst_n === 1'b1);
        reset_and_first_fetch();
        same_line_hits();
        lru_replacement();
        error_refill();
        flush_walk();
        random_fetches();
        $display("tests: %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/icache_cfg_pkg.sv
source/icache_if_pkg.sv
source/sp_ram.sv
source/itag_ram.sv
source/idata_ram.sv
source/icache_ctrl.sv
source/icache_top.sv
sim/clk_rst_gen.sv
sim/axi_rom_model.sv
sim/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - source/icache_cfg_pkg.sv
      - source/icache_if_pkg.sv
      - source/sp_ram.sv
      - source/itag_ram.sv
      - source/idata_ram.sv
      - source/icache_ctrl.sv
      - source/icache_top.sv
  - target: simulation
    files:
      - sim/clk_rst_gen.sv
      - sim/axi_rom_model.sv
      - sim/tb_icache.sv
